//--- project.f
+incdir+src
src/access_pkg.sv
src/ram_pkg.sv
src/lsu_store_align.sv
src/data_ram.sv
src/lsu_load_align.sv
src/lsu_top.sv
sim/lsu_props.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the LSU testbench with Verilator, run it, then look for the pass message in the log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module lsu_tb -f project.f -o lsu_sim \
    > build.log 2>&1 \
    && ./obj_dir/lsu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

[ -f sim.log ] && cat sim.log

grep -q "Test completed successfully" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/lsu_checker.sv
//******************************
// watches lsu_top, keeps a byte copy of the RAM
// bytes never stored hold no known value
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`XLEN-1:0]          raddr,
    input  wire                      ren,
    input  wire [`XLEN-1:0]          waddr,
    input  wire [`XLEN-1:0]          wdata,
    input  wire                      wen,
    input  wire access_pkg::mem_op_u op,
    input  wire [`XLEN-1:0]          rdata,
    input  wire                      rvalid,
    input  wire                      misaligned,
    output int                       error_count,
    output int                       check_count,
    output int                       pending
);

    import access_pkg::*;

    localparam int idx_bits = `RAM_ADDR_BITS + 3;

    typedef logic [idx_bits-1:0] byte_idx_t;

    // byte copy of the RAM, written from the DUT inputs
    logic [7:0] shadow [2 ** idx_bits];

    // expected results in issue order
    logic [`XLEN-1:0] exp_data_q [$];
    logic             exp_mis_q [$];
    logic [`XLEN-1:0] exp_addr_q [$];
    int               due_q [$];
    int               cycle;

    function automatic int width_bytes(input mem_width_e width);
        return 1 << int'(width);
    endfunction

    function automatic logic misaligned_at(input logic [`XLEN-1:0] addr, input mem_width_e width);
        return (int'(addr[2:0]) % width_bytes(width)) != 0;
    endfunction

    // wraps on the RAM size
    function automatic byte_idx_t byte_index(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] rel;
        rel = addr - `RAM_BASE;
        return rel[idx_bits-1:0];
    endfunction

    // lane at the offset, then sign or zero extension
    function automatic logic [`XLEN-1:0] expect_load(input logic [`XLEN-1:0] addr,
                                                     input mem_op_u f);
        logic [`XLEN-1:0] val;
        logic [`XLEN-1:0] top;
        logic [`XLEN-1:0] keep;
        int               size;
        byte_idx_t        base;
        logic             sign;
        size = width_bytes(f.dec.width);
        base = byte_index(addr);
        val  = '0;
        if (misaligned_at(addr, f.dec.width)) begin
            return '0;
        end
        for (int i = 0; i < size; i++) begin
            val = val | ({56'd0, shadow[base + byte_idx_t'(i)]} << (i * 8));
        end
        top  = val >> (size * 8 - 1);
        sign = (size < 8) && !f.dec.is_unsigned && top[0];
        keep = (size == 8) ? '1 : ((64'd1 << (size * 8)) - 64'd1);
        return val | (~keep & {`XLEN{sign}});
    endfunction

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
        cycle       = 0;
    end

    always @(posedge clk) begin
        logic             exp_mis;
        logic [`XLEN-1:0] exp_data;
        logic [`XLEN-1:0] exp_addr;
        byte_idx_t        base;
        if (rst) begin
            exp_data_q.delete();
            exp_mis_q.delete();
            exp_addr_q.delete();
            due_q.delete();
            cycle   = 0;
            pending = 0;
        end else begin
            // store flag shows in the cycle of the store
            exp_mis = wen && misaligned_at(waddr, op.dec.width);
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                exp_data = exp_data_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                exp_mis  = exp_mis | exp_mis_q.pop_front();
                void'(due_q.pop_front());
                check_count++;
                if (!rvalid) begin
                    $display("Error at %0t: no rvalid for the load from 0x%h", $time, exp_addr);
                    error_count++;
                end else if (rdata !== exp_data) begin
                    $display("Mismatch at %0t: load from 0x%h returned 0x%h, expected 0x%h",
                             $time, exp_addr, rdata, exp_data);
                    error_count++;
                end
            end else if (rvalid) begin
                $display("Error at %0t: rvalid with no load outstanding", $time);
                error_count++;
            end
            if (misaligned !== exp_mis) begin
                $display("Mismatch at %0t: misaligned is %b, expected %b",
                         $time, misaligned, exp_mis);
                error_count++;
            end
            // expected value uses memory before this edge's store
            if (ren) begin
                exp_data_q.push_back(expect_load(raddr, op));
                exp_mis_q.push_back(misaligned_at(raddr, op.dec.width));
                exp_addr_q.push_back(raddr);
                due_q.push_back(cycle + 2);
            end
            if (wen && !misaligned_at(waddr, op.dec.width)) begin
                base = byte_index(waddr);
                for (int i = 0; i < width_bytes(op.dec.width); i++) begin
                    shadow[base + byte_idx_t'(i)] = 8'(wdata >> (i * 8));
                end
            end
            cycle++;
            pending = due_q.size();
        end
    end

endmodule

`default_nettype wire

//--- sim/lsu_props.sv
//******************************
// strobe timing of lsu_top, attached by bind
// fail_count holds the number of failed property checks
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_props (
    input wire             clk,
    input wire             rst,
    input wire             ren,
    input wire             rvalid,
    input wire             misaligned,
    input wire [`XLEN-1:0] rdata
);

    int fail_count;

    initial fail_count = 0;

    // one rvalid per ren, two sampling edges later
    rvalid_tracks_ren: assert property (
        @(posedge clk) disable iff (rst) rvalid == $past(ren, 2)
    ) else begin
        $error("rvalid does not match ren from two edges earlier");
        fail_count++;
    end

    // quiet outputs right after reset
    quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!rvalid && !misaligned)
    ) else begin
        $error("rvalid or misaligned high in the cycle after reset");
        fail_count++;
    end

    // rdata only moves together with rvalid
    rdata_holds: assert property (
        @(posedge clk) disable iff (rst) !rvalid |-> $stable(rdata)
    ) else begin
        $error("rdata changed without rvalid");
        fail_count++;
    end

endmodule

bind lsu_top lsu_props lsu_props_i (
    .clk        (clk),
    .rst        (rst),
    .ren        (ren),
    .rvalid     (rvalid),
    .misaligned (misaligned),
    .rdata      (rdata)
);

`default_nettype wire

//--- sim/lsu_tb.sv
//******************************
// drives lsu_top, checking is done in lsu_checker
// traffic stays in doublewords 0 to 15, all written first
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;

    import access_pkg::*;

    localparam logic [2:0] op_b  = 3'b000;
    localparam logic [2:0] op_h  = 3'b001;
    localparam logic [2:0] op_w  = 3'b010;
    localparam logic [2:0] op_d  = 3'b011;
    localparam logic [2:0] op_bu = 3'b100;
    localparam logic [2:0] op_hu = 3'b101;
    localparam logic [2:0] op_wu = 3'b110;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] raddr;
    logic             ren;
    logic [`XLEN-1:0] waddr;
    logic [`XLEN-1:0] wdata;
    logic             wen;
    mem_op_u          op;
    logic [`XLEN-1:0] rdata;
    logic             rvalid;
    logic             misaligned;

    int error_count;
    int check_count;
    int pending;
    int timeout_count;
    int seed;
    int test_num;
    int test_errors;
    int test_checks;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    lsu_top lsu_top_i (
        .clk        (clk),
        .rst        (rst),
        .raddr      (raddr),
        .ren        (ren),
        .waddr      (waddr),
        .wdata      (wdata),
        .wen        (wen),
        .op         (op),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .misaligned (misaligned)
    );

    lsu_checker lsu_checker_i (
        .clk         (clk),
        .rst         (rst),
        .raddr       (raddr),
        .ren         (ren),
        .waddr       (waddr),
        .wdata       (wdata),
        .wen         (wen),
        .op          (op),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .misaligned  (misaligned),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    function automatic logic [`XLEN-1:0] addr_of(input int dw, input int off);
        return `RAM_BASE + 64'(dw * 8 + off);
    endfunction

    function automatic logic [`XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // sampled by the DUT at the following edge
    task automatic drive_cycle(input logic r, input logic [`XLEN-1:0] ra, input logic w,
                               input logic [`XLEN-1:0] wa, input logic [`XLEN-1:0] wd,
                               input logic [2:0] f3);
        @(posedge clk);
        ren       <= r;
        raddr     <= ra;
        wen       <= w;
        waddr     <= wa;
        wdata     <= wd;
        op.funct3 <= f3;
    endtask

    task automatic store(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] d,
                         input logic [2:0] f3);
        drive_cycle(1'b0, '0, 1'b1, a, d, f3);
    endtask

    task automatic load(input logic [`XLEN-1:0] a, input logic [2:0] f3);
        drive_cycle(1'b1, a, 1'b0, '0, '0, f3);
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0, 1'b0, '0, '0, 3'b000);
    endtask

    task automatic finish_run();
        int props_fails;
        props_fails = lsu_top_i.lsu_props_i.fail_count;
        $display("%0d loads checked, %0d errors, %0d assertion failures, %0d timeouts",
                 check_count, error_count, props_fails, timeout_count);
        if (error_count == 0 && props_fails == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (pending != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("Timed out after %0d cycles waiting for the loads of test %0d (%s)",
                     n, test_num, name);
            timeout_count++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        int chks;
        idle();
        wait_drain(name);
        errs = error_count - test_errors;
        chks = check_count - test_checks;
        $display("test %0d %s: %0d loads checked, %0d errors, %s",
                 test_num, name, chks, errs, errs == 0 ? "passed" : "FAILED");
        test_num++;
        test_errors = error_count;
        test_checks = check_count;
    endtask

    initial begin
        logic [31:0]      r;
        logic [`XLEN-1:0] ra;
        logic [`XLEN-1:0] wa;
        seed          = 32'he71fbad9;
        rst           = 1'b1;
        ren           = 1'b0;
        raddr         = '0;
        wen           = 1'b0;
        waddr         = '0;
        wdata         = '0;
        op            = '0;
        timeout_count = 0;
        test_num      = 1;
        test_errors   = 0;
        test_checks   = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        repeat (4) idle();
        for (int i = 0; i < 16; i++) store(addr_of(i, 0), rand64(), op_d);
        for (int i = 0; i < 16; i++) load(addr_of(i, 0), op_d);
        // one past the RAM size wraps to index 0
        load(addr_of(256, 0), op_d);
        end_test("reset and dword write/read");

        for (int o = 0; o < 8; o++) begin
            store(addr_of(2, o), rand64(), op_b);
            load(addr_of(2, 0), op_d);
        end
        for (int o = 0; o < 8; o += 2) begin
            store(addr_of(3, o), rand64(), op_h);
            load(addr_of(3, 0), op_d);
        end
        end_test("byte and half store lanes");

        // both signs in every byte, half and word lane
        store(addr_of(4, 0), 64'h8001_7ffe_ff80_7f00, op_d);
        store(addr_of(5, 0), 64'h7fff_ffff_8000_0001, op_d);
        for (int dw = 4; dw < 6; dw++) begin
            for (int o = 0; o < 8; o++) begin
                load(addr_of(dw, o), op_b);
                load(addr_of(dw, o), op_bu);
                if (o % 2 == 0) begin
                    load(addr_of(dw, o), op_h);
                    load(addr_of(dw, o), op_hu);
                end
                if (o % 4 == 0) begin
                    load(addr_of(dw, o), op_w);
                    load(addr_of(dw, o), op_wu);
                end
            end
        end
        end_test("load sign and zero extension");

        for (int o = 1; o < 8; o++) begin
            if (o % 2 == 1) store(addr_of(6, o), rand64(), op_h);
            if (o % 4 != 0) store(addr_of(6, o), rand64(), op_w);
            store(addr_of(6, o), rand64(), op_d);
            load(addr_of(7, o), op_d);
            if (o % 2 == 1) load(addr_of(7, o), op_hu);
            if (o % 4 != 0) load(addr_of(7, o), op_w);
        end
        load(addr_of(6, 0), op_d);
        end_test("misaligned stores and loads");

        for (int n = 0; n < 300; n++) begin
            r  = $random(seed);
            ra = addr_of(int'(r[3:0]), int'(r[6:4]));
            wa = addr_of(int'(r[10:7]), int'(r[13:11]));
            if (r[19]) begin
                ra[2:0] = 3'b000;
                wa[2:0] = 3'b000;
            end
            // read and write of one doubleword in the same cycle
            if (n % 8 == 0) begin
                wa = {ra[`XLEN-1:3], wa[2:0]};
            end
            drive_cycle(r[14] || (n % 8 == 0), ra, r[15] || (n % 8 == 0), wa, rand64(),
                        r[18:16]);
        end
        end_test("random back-to-back traffic");

        finish_run();
    end

endmodule

`default_nettype wire

//--- src/access_pkg.sv
//******************************
// memory operation encoding, follows RISC-V load/store funct3
// funct3[2] is the unsigned flag, funct3[1:0] the access width
//******************************
`default_nettype none

package access_pkg;

    // funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        width_byte  = 2'b00,
        width_half  = 2'b01,
        width_word  = 2'b10,
        width_dword = 2'b11
    } mem_width_e;

    // funct3 seen as its two fields
    typedef struct packed {
        logic       is_unsigned;
        mem_width_e width;
    } mem_op_s;

    // raw opcode field or decoded view of the same three bits
    typedef union packed {
        logic [2:0] funct3;
        mem_op_s    dec;
    } mem_op_u;

    // natural alignment, address is a multiple of the access size
    function automatic logic is_aligned(input mem_width_e width, input logic [2:0] offset);
        case (width)
            width_byte: return 1'b1;
            width_half: return offset[0] == 1'b0;
            width_word: return offset[1:0] == 2'b00;
            default:    return offset == 3'b000;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/data_ram.sv
//******************************
// 64 bit wide RAM, byte enable write, registered read
// same-cycle read and write of one word returns the old data
// contents are not initialised
//******************************
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  wire                      clk,
    input  wire                      rd_en,
    input  wire ram_pkg::ram_index_t rd_index,
    input  wire ram_pkg::ram_index_t wr_index,
    input  wire ram_pkg::byte_mask_t wr_mask,
    input  wire ram_pkg::dword_t     wr_data,
    output ram_pkg::dword_t          rd_data
);

    import ram_pkg::*;

    dword_t mem [ram_depth];

    // one enable per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < bytes_per_dword; b++) begin
            if (wr_mask[b]) begin
                mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

    // read register holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_load_align.sv
//******************************
// load path, index out now, aligned result two edges later
// misaligned loads return zero with ld_misaligned on rvalid
// one load per cycle, no back-pressure
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_align (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`XLEN-1:0]          raddr,
    input  wire                      ren,
    input  wire access_pkg::mem_op_u op,
    output ram_pkg::ram_index_t      rd_index,
    output logic                     rd_en,
    output logic [`XLEN-1:0]         rdata,
    output logic                     rvalid,
    output logic                     ld_misaligned,
    input  wire ram_pkg::dword_t     rd_data
);

    import access_pkg::*;
    import ram_pkg::*;

    // request info kept while the RAM read is in flight
    logic       pend_valid;
    logic [2:0] pend_offset;
    mem_op_u    pend_op;
    logic       pend_aligned;

    dword_t           lane;
    logic [`XLEN-1:0] ext;

    assign rd_index = addr_to_index(raddr);
    assign rd_en    = ren;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= ren;
        end
    end

    always_ff @(posedge clk) begin
        if (ren) begin
            pend_offset  <= raddr[2:0];
            pend_op      <= op;
            pend_aligned <= is_aligned(op.dec.width, raddr[2:0]);
        end
    end

    // addressed lane moved down to bit 0, then extended
    always_comb begin
        lane = rd_data >> {pend_offset, 3'b000};
        case (pend_op.dec.width)
            width_byte: begin
                if (pend_op.dec.is_unsigned) begin
                    ext = {{(`XLEN-8){1'b0}}, lane[7:0]};
                end else begin
                    ext = {{(`XLEN-8){lane[7]}}, lane[7:0]};
                end
            end
            width_half: begin
                if (pend_op.dec.is_unsigned) begin
                    ext = {{(`XLEN-16){1'b0}}, lane[15:0]};
                end else begin
                    ext = {{(`XLEN-16){lane[15]}}, lane[15:0]};
                end
            end
            width_word: begin
                if (pend_op.dec.is_unsigned) begin
                    ext = {{(`XLEN-32){1'b0}}, lane[31:0]};
                end else begin
                    ext = {{(`XLEN-32){lane[31]}}, lane[31:0]};
                end
            end
            // full doubleword, the unsigned bit has no effect
            default: ext = lane;
        endcase
    end

    // rdata only changes together with rvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid        <= 1'b0;
            ld_misaligned <= 1'b0;
            rdata         <= '0;
        end else begin
            rvalid        <= pend_valid;
            ld_misaligned <= pend_valid && !pend_aligned;
            if (pend_valid) begin
                rdata <= pend_aligned ? ext : '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_macros.svh
//******************************
// global sizes for the load/store unit
// the RAM holds 2^RAM_ADDR_BITS doublewords from RAM_BASE
// addresses outside that window wrap on the index bits
//******************************
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// register and data path width
`define XLEN 64

// doubleword index width, 256 x 64 bit by default
`define RAM_ADDR_BITS 8

// byte address that maps to RAM index 0
`define RAM_BASE 64'h0000_0000_8000_0000

`endif

//--- src/lsu_store_align.sv
//******************************
// store lane alignment, purely combinational
// misaligned stores raise st_misaligned and write nothing
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_store_align (
    input  wire [`XLEN-1:0]         waddr,
    input  wire [`XLEN-1:0]         wdata,
    input  wire                     wen,
    input  wire access_pkg::mem_op_u op,
    output ram_pkg::ram_index_t     wr_index,
    output ram_pkg::byte_mask_t     wr_mask,
    output ram_pkg::dword_t         wr_data,
    output logic                    st_misaligned
);

    import access_pkg::*;
    import ram_pkg::*;

    logic [2:0] offset;
    byte_mask_t width_mask;
    logic       aligned;

    // byte position inside the doubleword
    assign offset = waddr[2:0];

    assign wr_index = addr_to_index(waddr);

    // lanes covered by the access, before shifting
    always_comb begin
        case (op.dec.width)
            width_byte: width_mask = 8'h01;
            width_half: width_mask = 8'h03;
            width_word: width_mask = 8'h0f;
            default:    width_mask = 8'hff;
        endcase
    end

    assign aligned = is_aligned(op.dec.width, offset);

    // flag only while a store is actually presented
    assign st_misaligned = wen && !aligned;

    // low data bits move up to the addressed lane
    assign wr_data = wdata << {offset, 3'b000};

    // no lanes enabled when idle or misaligned
    always_comb begin
        if (wen && aligned) begin
            wr_mask = width_mask << offset;
        end else begin
            wr_mask = '0;
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_top.sv
//******************************
// load/store unit with its data RAM
// misaligned merges the store flag (same cycle) and the load flag (on rvalid)
//******************************
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`XLEN-1:0]          raddr,
    input  wire                      ren,
    input  wire [`XLEN-1:0]          waddr,
    input  wire [`XLEN-1:0]          wdata,
    input  wire                      wen,
    input  wire access_pkg::mem_op_u op,
    output logic [`XLEN-1:0]         rdata,
    output logic                     rvalid,
    output logic                     misaligned
);

    import ram_pkg::*;

    ram_index_t wr_index;
    byte_mask_t wr_mask;
    dword_t     wr_data;
    ram_index_t rd_index;
    logic       rd_en;
    dword_t     rd_data;
    logic       st_misaligned;
    logic       ld_misaligned;

    lsu_store_align lsu_store_align_i (
        .waddr         (waddr),
        .wdata         (wdata),
        .wen           (wen),
        .op            (op),
        .wr_index      (wr_index),
        .wr_mask       (wr_mask),
        .wr_data       (wr_data),
        .st_misaligned (st_misaligned)
    );

    lsu_load_align lsu_load_align_i (
        .clk           (clk),
        .rst           (rst),
        .raddr         (raddr),
        .ren           (ren),
        .op            (op),
        .rd_index      (rd_index),
        .rd_en         (rd_en),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .ld_misaligned (ld_misaligned),
        .rd_data       (rd_data)
    );

    data_ram data_ram_i (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_index (wr_index),
        .wr_mask  (wr_mask),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

    assign misaligned = st_misaligned | ld_misaligned;

endmodule

`default_nettype wire

//--- src/ram_pkg.sv
//******************************
// RAM storage types, one word is 8 byte lanes
// index is taken after subtracting RAM_BASE, no range check
//******************************
`default_nettype none

package ram_pkg;

    `include "lsu_macros.svh"

    typedef logic [63:0]                dword_t;
    typedef logic [7:0]                 byte_mask_t;
    typedef logic [`RAM_ADDR_BITS-1:0] ram_index_t;

    localparam int ram_depth       = 2 ** `RAM_ADDR_BITS;
    localparam int bytes_per_dword = 8;

    // byte address to doubleword index, high bits wrap away
    function automatic ram_index_t addr_to_index(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] rel;
        rel = addr - `RAM_BASE;
        return rel[`RAM_ADDR_BITS+2:3];
    endfunction

endpackage

`default_nettype wire
